/* hw/dispatch_pkg.sv */
package dispatch_pkg;

    // Architectural register file size
    localparam int ARCH_REG_COUNT = 32;

    // Physical register file size
    localparam int PHYS_REG_COUNT = 64;

    // One reservation station bank per functional unit class
    localparam int BANK_COUNT = 4;

    // Architectural register index from decode
    typedef logic [$clog2(ARCH_REG_COUNT)-1:0] arch_idx_t;

    // Physical register tag
    typedef logic [$clog2(PHYS_REG_COUNT)-1:0] phys_tag_t;

    // Free slot count, wide enough to hold a completely free list
    typedef logic [$clog2(PHYS_REG_COUNT+1)-1:0] slot_count_t;

    // Reservation station bank, also used as an index into per-bank counters
    typedef enum logic [1:0] {
        BANK_ALU    = 2'd0,
        BANK_MULT   = 2'd1,
        BANK_BRANCH = 2'd2,
        BANK_MEM    = 2'd3
    } fu_bank_t;

endpackage

/* hw/dispatch_limiter.sv */
module dispatch_limiter import dispatch_pkg::*; #(
    parameter int DISPATCH_WIDTH = 4
) (
    input  logic [$clog2(DISPATCH_WIDTH+1)-1:0] valid_count,
    input  logic [DISPATCH_WIDTH-1:0]           uses_rd,
    input  fu_bank_t [DISPATCH_WIDTH-1:0]       bank,
    input  slot_count_t                         rob_free,
    input  slot_count_t                         rs_alu_free,
    input  slot_count_t                         rs_mult_free,
    input  slot_count_t                         rs_branch_free,
    input  slot_count_t                         rs_mem_free,
    input  slot_count_t                         phys_free_count,
    output logic [DISPATCH_WIDTH-1:0]           lane_fire,
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0] dispatch_count,
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0] pop_count
);

    localparam int CNT_W = $clog2(DISPATCH_WIDTH + 1);

    // Free slots per bank, indexed by the bank code
    slot_count_t [BANK_COUNT-1:0] bank_cap;
    // Running slot usage while walking the bundle
    slot_count_t [BANK_COUNT-1:0] bank_used;
    slot_count_t                  rob_used;
    slot_count_t                  rd_used;
    // Set at the first lane that cannot go, holds for the rest
    logic                         stop;

    assign bank_cap = {rs_mem_free, rs_branch_free, rs_mult_free, rs_alu_free};

    always_comb begin
        rob_used  = '0;
        rd_used   = '0;
        bank_used = '0;
        stop      = 1'b0;
        lane_fire = '0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            // Lane not offered by decode
            if (i >= int'(valid_count)) begin
                stop = 1'b1;
            end
            // Out of ROB entries
            if (rob_used >= rob_free) begin
                stop = 1'b1;
            end
            // Target bank is full
            if (bank_used[bank[i]] >= bank_cap[bank[i]]) begin
                stop = 1'b1;
            end
            // Needs a destination tag but none left
            if (uses_rd[i] && (rd_used >= phys_free_count)) begin
                stop = 1'b1;
            end
            if (!stop) begin
                lane_fire[i]       = 1'b1;
                rob_used           = rob_used + slot_count_t'(1);
                bank_used[bank[i]] = bank_used[bank[i]] + slot_count_t'(1);
                if (uses_rd[i]) begin
                    rd_used = rd_used + slot_count_t'(1);
                end
            end
        end
    end

    // Every fired lane takes one ROB entry, so the ROB usage is the count
    assign dispatch_count = CNT_W'(rob_used);
    // Tags consumed from the free list this cycle
    assign pop_count      = CNT_W'(rd_used);

    // Decode must never be told to drop more lanes than it offered
    always_comb begin
        assert final (dispatch_count <= valid_count)
            else $error("dispatch_count %0d above valid_count %0d", dispatch_count, valid_count);
    end

endmodule

/* hw/rename_map.sv */
module rename_map import dispatch_pkg::*; #(
    parameter int DISPATCH_WIDTH = 4
) (
    input  logic                              clock,
    input  logic                              rst_n,
    input  arch_idx_t [DISPATCH_WIDTH-1:0]    rs1_idx,
    input  arch_idx_t [DISPATCH_WIDTH-1:0]    rs2_idx,
    input  arch_idx_t [DISPATCH_WIDTH-1:0]    rd_idx,
    input  logic [DISPATCH_WIDTH-1:0]         map_we,
    input  phys_tag_t [DISPATCH_WIDTH-1:0]    map_wtag,
    output phys_tag_t [DISPATCH_WIDTH-1:0]    rs1_map,
    output phys_tag_t [DISPATCH_WIDTH-1:0]    rs2_map,
    output phys_tag_t [DISPATCH_WIDTH-1:0]    rd_map
);

    // Speculative architectural to physical mapping
    phys_tag_t map_q [ARCH_REG_COUNT];

    // Three read ports per lane, no forwarding from this cycle's writes
    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            rs1_map[i] = map_q[rs1_idx[i]];
            rs2_map[i] = map_q[rs2_idx[i]];
            // Previous mapping of rd, reported as the old tag
            rd_map[i]  = map_q[rd_idx[i]];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // Identity map, register r lives in physical register r
            for (int r = 0; r < ARCH_REG_COUNT; r++) begin
                map_q[r] <= phys_tag_t'(r);
            end
        end else begin
            // Lanes applied in order so the youngest write to an rd wins
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (map_we[i]) begin
                    map_q[rd_idx[i]] <= map_wtag[i];
                end
            end
        end
    end

endmodule

/* hw/phys_free_list.sv */
module phys_free_list import dispatch_pkg::*; #(
    parameter int DISPATCH_WIDTH = 4
) (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic [$clog2(DISPATCH_WIDTH+1)-1:0] pop_count,
    input  logic                              retire_valid,
    input  phys_tag_t                         retire_tag,
    output phys_tag_t [DISPATCH_WIDTH-1:0]    head_tags,
    output slot_count_t                       phys_free_count
);

    localparam int PTR_W     = $clog2(PHYS_REG_COUNT);
    // Tags not covered by the identity map at reset
    localparam int INIT_FREE = PHYS_REG_COUNT - ARCH_REG_COUNT;

    // Circular buffer of free tags
    phys_tag_t        fifo_q [PHYS_REG_COUNT];
    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    slot_count_t      count_q;

    // Oldest free tags first, pointer wraps on its own width
    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            head_tags[i] = fifo_q[head_q + PTR_W'(i)];
        end
    end

    assign phys_free_count = count_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= PTR_W'(INIT_FREE);
            count_q <= slot_count_t'(INIT_FREE);
            // Entry k holds tag ARCH_REG_COUNT + k, ascending
            for (int k = 0; k < PHYS_REG_COUNT; k++) begin
                fifo_q[k] <= phys_tag_t'(ARCH_REG_COUNT + k);
            end
        end else begin
            head_q  <= head_q + PTR_W'(pop_count);
            count_q <= count_q - slot_count_t'(pop_count) + slot_count_t'(retire_valid);
            // One retired tag per cycle goes behind all older free tags
            if (retire_valid) begin
                fifo_q[tail_q] <= retire_tag;
                tail_q         <= tail_q + PTR_W'(1);
            end
        end
    end

    // Retire returns a tag only while some tag is still out
    assert property (@(posedge clock) disable iff (!rst_n)
        retire_valid |-> (count_q < slot_count_t'(PHYS_REG_COUNT)))
        else $error("retire of tag %0d into a full free list", retire_tag);

    // Limiter never takes more tags than the list holds
    assert property (@(posedge clock) disable iff (!rst_n)
        slot_count_t'(pop_count) <= count_q)
        else $error("pop of %0d tags with %0d free", pop_count, count_q);

endmodule

/* hw/ready_table.sv */
module ready_table import dispatch_pkg::*; #(
    parameter int DISPATCH_WIDTH = 4
) (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           wb_valid,
    input  phys_tag_t                      wb_tag,
    input  logic [DISPATCH_WIDTH-1:0]      alloc_valid,
    input  phys_tag_t [DISPATCH_WIDTH-1:0] alloc_tag,
    input  phys_tag_t [DISPATCH_WIDTH-1:0] rs1_map,
    input  phys_tag_t [DISPATCH_WIDTH-1:0] rs2_map,
    output logic [DISPATCH_WIDTH-1:0]      rs1_ready_raw,
    output logic [DISPATCH_WIDTH-1:0]      rs2_ready_raw
);

    // One bit per physical register, set means value is available
    logic [PHYS_REG_COUNT-1:0] ready_q;

    // Lookups on the mapped source tags, before in-bundle forwarding
    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            rs1_ready_raw[i] = ready_q[rs1_map[i]];
            rs2_ready_raw[i] = ready_q[rs2_map[i]];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            // Committed state at reset, every register holds a value
            ready_q <= '1;
        end else begin
            if (wb_valid) begin
                ready_q[wb_tag] <= 1'b1;
            end
            // Allocation comes last so a fresh tag stays pending
            for (int i = 0; i < DISPATCH_WIDTH; i++) begin
                if (alloc_valid[i]) begin
                    ready_q[alloc_tag[i]] <= 1'b0;
                end
            end
        end
    end

endmodule

/* hw/rename_bypass.sv */
module rename_bypass import dispatch_pkg::*; #(
    parameter int DISPATCH_WIDTH = 4
) (
    input  arch_idx_t [DISPATCH_WIDTH-1:0] rs1_idx,
    input  arch_idx_t [DISPATCH_WIDTH-1:0] rs2_idx,
    input  arch_idx_t [DISPATCH_WIDTH-1:0] rd_idx,
    input  logic [DISPATCH_WIDTH-1:0]      uses_rd,
    input  logic [DISPATCH_WIDTH-1:0]      uses_rs2,
    input  logic [DISPATCH_WIDTH-1:0]      lane_fire,
    input  phys_tag_t [DISPATCH_WIDTH-1:0] rs1_map,
    input  phys_tag_t [DISPATCH_WIDTH-1:0] rs2_map,
    input  phys_tag_t [DISPATCH_WIDTH-1:0] rd_map,
    input  logic [DISPATCH_WIDTH-1:0]      rs1_ready_raw,
    input  logic [DISPATCH_WIDTH-1:0]      rs2_ready_raw,
    input  phys_tag_t [DISPATCH_WIDTH-1:0] head_tags,
    output phys_tag_t [DISPATCH_WIDTH-1:0] src1_tag,
    output logic [DISPATCH_WIDTH-1:0]      src1_ready,
    output phys_tag_t [DISPATCH_WIDTH-1:0] src2_tag,
    output logic [DISPATCH_WIDTH-1:0]      src2_ready,
    output phys_tag_t [DISPATCH_WIDTH-1:0] dest_tag,
    output phys_tag_t [DISPATCH_WIDTH-1:0] old_tag,
    output logic [DISPATCH_WIDTH-1:0]      map_we,
    output phys_tag_t [DISPATCH_WIDTH-1:0] map_wtag,
    output logic [DISPATCH_WIDTH-1:0]      alloc_valid,
    output phys_tag_t [DISPATCH_WIDTH-1:0] alloc_tag
);

    // Destination tags, handed out from the free list head in lane order
    always_comb begin
        int alloc_n;
        alloc_n = 0;
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            map_we[i]   = lane_fire[i] & uses_rd[i];
            dest_tag[i] = head_tags[alloc_n];
            if (map_we[i]) begin
                alloc_n++;
            end
        end
    end

    // Forwarding from older renaming lanes, nearest one wins
    always_comb begin
        for (int i = 0; i < DISPATCH_WIDTH; i++) begin
            src1_tag[i]   = rs1_map[i];
            src1_ready[i] = rs1_ready_raw[i];
            src2_tag[i]   = rs2_map[i];
            src2_ready[i] = rs2_ready_raw[i];
            old_tag[i]    = rd_map[i];
            for (int j = 0; j < i; j++) begin
                if (map_we[j]) begin
                    // Producer is in flight in this same bundle
                    if (rd_idx[j] == rs1_idx[i]) begin
                        src1_tag[i]   = dest_tag[j];
                        src1_ready[i] = 1'b0;
                    end
                    if (rd_idx[j] == rs2_idx[i]) begin
                        src2_tag[i]   = dest_tag[j];
                        src2_ready[i] = 1'b0;
                    end
                    // Old tag is the older lane's new tag, freed when this lane retires
                    if (rd_idx[j] == rd_idx[i]) begin
                        old_tag[i] = dest_tag[j];
                    end
                end
            end
            // Unused rs2 never holds up issue
            if (!uses_rs2[i]) begin
                src2_ready[i] = 1'b1;
            end
        end
    end

    assign map_wtag    = dest_tag;
    // Same lanes that remap also mark their new tag pending
    assign alloc_valid = map_we;
    assign alloc_tag   = dest_tag;

endmodule

/* hw/rename_dispatch.sv */
module rename_dispatch import dispatch_pkg::*; #(
    parameter int DISPATCH_WIDTH = 4
) (
    input  logic                                clock,
    input  logic                                rst_n,
    // Decoded bundle, lane 0 oldest
    input  logic [$clog2(DISPATCH_WIDTH+1)-1:0] valid_count,
    input  arch_idx_t [DISPATCH_WIDTH-1:0]      rs1_idx,
    input  arch_idx_t [DISPATCH_WIDTH-1:0]      rs2_idx,
    input  arch_idx_t [DISPATCH_WIDTH-1:0]      rd_idx,
    input  logic [DISPATCH_WIDTH-1:0]           uses_rd,
    input  logic [DISPATCH_WIDTH-1:0]           uses_rs2,
    input  fu_bank_t [DISPATCH_WIDTH-1:0]       bank,
    // Downstream capacity
    input  slot_count_t                         rob_free,
    input  slot_count_t                         rs_alu_free,
    input  slot_count_t                         rs_mult_free,
    input  slot_count_t                         rs_branch_free,
    input  slot_count_t                         rs_mem_free,
    // Completion and commit
    input  logic                                wb_valid,
    input  phys_tag_t                           wb_tag,
    input  logic                                retire_valid,
    input  phys_tag_t                           retire_tag,
    // Lanes accepted this cycle, zero means stall
    output logic [$clog2(DISPATCH_WIDTH+1)-1:0] dispatch_count,
    // Renamed lanes, valid below dispatch_count
    output fu_bank_t [DISPATCH_WIDTH-1:0]       lane_bank,
    output phys_tag_t [DISPATCH_WIDTH-1:0]      src1_tag,
    output logic [DISPATCH_WIDTH-1:0]           src1_ready,
    output phys_tag_t [DISPATCH_WIDTH-1:0]      src2_tag,
    output logic [DISPATCH_WIDTH-1:0]           src2_ready,
    output phys_tag_t [DISPATCH_WIDTH-1:0]      dest_tag,
    output phys_tag_t [DISPATCH_WIDTH-1:0]      old_tag
);

    // Limiter results
    logic [DISPATCH_WIDTH-1:0]           lane_fire;
    logic [$clog2(DISPATCH_WIDTH+1)-1:0] pop_count;
    // Free list state
    slot_count_t                         phys_free_count;
    phys_tag_t [DISPATCH_WIDTH-1:0]      head_tags;
    // Map and ready lookups
    phys_tag_t [DISPATCH_WIDTH-1:0]      rs1_map;
    phys_tag_t [DISPATCH_WIDTH-1:0]      rs2_map;
    phys_tag_t [DISPATCH_WIDTH-1:0]      rd_map;
    logic [DISPATCH_WIDTH-1:0]           rs1_ready_raw;
    logic [DISPATCH_WIDTH-1:0]           rs2_ready_raw;
    // State updates at the next edge
    logic [DISPATCH_WIDTH-1:0]           map_we;
    phys_tag_t [DISPATCH_WIDTH-1:0]      map_wtag;
    logic [DISPATCH_WIDTH-1:0]           alloc_valid;
    phys_tag_t [DISPATCH_WIDTH-1:0]      alloc_tag;

    // Bank code goes straight to the reservation station router
    assign lane_bank = bank;

    dispatch_limiter #(.DISPATCH_WIDTH(DISPATCH_WIDTH)) dispatch_limiter_inst (.*);

    rename_map #(.DISPATCH_WIDTH(DISPATCH_WIDTH)) rename_map_inst (.*);

    phys_free_list #(.DISPATCH_WIDTH(DISPATCH_WIDTH)) phys_free_list_inst (.*);

    ready_table #(.DISPATCH_WIDTH(DISPATCH_WIDTH)) ready_table_inst (.*);

    rename_bypass #(.DISPATCH_WIDTH(DISPATCH_WIDTH)) rename_bypass_inst (.*);

endmodule

/* tests/tb_rename_dispatch.sv */
module tb_rename_dispatch import dispatch_pkg::*;;

    localparam int W  = 4;
    localparam int CW = $clog2(W + 1);

    logic                 clock;
    logic                 rst_n;
    logic [CW-1:0]        valid_count;
    arch_idx_t [W-1:0]    rs1_idx;
    arch_idx_t [W-1:0]    rs2_idx;
    arch_idx_t [W-1:0]    rd_idx;
    logic [W-1:0]         uses_rd;
    logic [W-1:0]         uses_rs2;
    fu_bank_t [W-1:0]     bank;
    slot_count_t          rob_free;
    slot_count_t          rs_alu_free;
    slot_count_t          rs_mult_free;
    slot_count_t          rs_branch_free;
    slot_count_t          rs_mem_free;
    logic                 wb_valid;
    phys_tag_t            wb_tag;
    logic                 retire_valid;
    phys_tag_t            retire_tag;
    logic [CW-1:0]        dispatch_count;
    fu_bank_t [W-1:0]     lane_bank;
    phys_tag_t [W-1:0]    src1_tag;
    logic [W-1:0]         src1_ready;
    phys_tag_t [W-1:0]    src2_tag;
    logic [W-1:0]         src2_ready;
    phys_tag_t [W-1:0]    dest_tag;
    phys_tag_t [W-1:0]    old_tag;

    // Reference model state
    phys_tag_t                 ref_map [ARCH_REG_COUNT];
    logic [PHYS_REG_COUNT-1:0] ref_ready;
    phys_tag_t                 ref_free [$];
    // Old tags of dispatched lanes that later come back as retires
    phys_tag_t                 retirable [$];

    // Expected results refreshed at each falling edge
    logic                 exp_valid;
    logic [CW-1:0]        exp_count;
    logic [W-1:0]         fire;
    logic [W-1:0]         exp_r1;
    logic [W-1:0]         exp_r2;
    phys_tag_t [W-1:0]    exp_src1;
    phys_tag_t [W-1:0]    exp_src2;
    phys_tag_t [W-1:0]    exp_dest;
    phys_tag_t [W-1:0]    exp_old;
    phys_tag_t [W-1:0]    tag_mask;
    phys_tag_t [W-1:0]    dest_mask;
    logic [2*W-1:0]       exp_bank;
    logic [2*W-1:0]       bank_mask;

    int     count_err;
    int     src_err;
    int     dest_err;
    int     bank_err;
    int     wait_err;
    integer seed;

    rename_dispatch #(.DISPATCH_WIDTH(W)) rename_dispatch_inst (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Prefix rule and renaming with in-bundle forwarding
    always @(negedge clock) begin
        int        cap [4];
        int        used [4];
        int        rob_n;
        int        pop_n;
        bit        fresh [ARCH_REG_COUNT];
        phys_tag_t cur [ARCH_REG_COUNT];
        if (rst_n) begin
            cap   = '{int'(rs_alu_free), int'(rs_mult_free), int'(rs_branch_free),
                      int'(rs_mem_free)};
            used  = '{default: 0};
            fresh = '{default: 0};
            cur   = ref_map;
            rob_n = 0;
            pop_n = 0;
            fire      = '0;
            tag_mask  = '0;
            dest_mask = '0;
            bank_mask = '0;
            exp_bank  = bank;
            for (int i = 0; i < W; i++) begin
                // First blocked lane ends the accepted prefix
                if (i >= int'(valid_count) || rob_n >= int'(rob_free)
                    || used[bank[i]] >= cap[bank[i]]
                    || (uses_rd[i] && pop_n >= ref_free.size())) begin
                    break;
                end
                fire[i]             = 1'b1;
                tag_mask[i]         = '1;
                bank_mask[2*i +: 2] = 2'b11;
                rob_n++;
                used[bank[i]]++;
                exp_src1[i] = cur[rs1_idx[i]];
                exp_r1[i]   = !fresh[rs1_idx[i]] && ref_ready[cur[rs1_idx[i]]];
                exp_src2[i] = cur[rs2_idx[i]];
                // Unused rs2 reads as ready
                exp_r2[i]   = !uses_rs2[i] || (!fresh[rs2_idx[i]] && ref_ready[cur[rs2_idx[i]]]);
                exp_old[i]  = cur[rd_idx[i]];
                if (uses_rd[i]) begin
                    dest_mask[i]     = '1;
                    exp_dest[i]      = ref_free[pop_n];
                    cur[rd_idx[i]]   = ref_free[pop_n];
                    fresh[rd_idx[i]] = 1'b1;
                    pop_n++;
                end
            end
            exp_count = CW'(rob_n);
            exp_valid = 1'b1;
        end
    end

    assert property (@(posedge clock) disable iff (!rst_n || !exp_valid)
        dispatch_count == exp_count)
        else begin
            count_err = count_err + 1;
            $display("Mismatch at %0t: dispatch_count, expected %0d", $time, exp_count);
        end

    assert property (@(posedge clock) disable iff (!rst_n || !exp_valid)
        ((src1_tag ^ exp_src1) & tag_mask) == '0 && ((src2_tag ^ exp_src2) & tag_mask) == '0
        && ((src1_ready ^ exp_r1) & fire) == '0 && ((src2_ready ^ exp_r2) & fire) == '0)
        else begin
            src_err = src_err + 1;
            $display("Mismatch at %0t: source tag or ready bit on a fired lane", $time);
        end

    assert property (@(posedge clock) disable iff (!rst_n || !exp_valid)
        ((dest_tag ^ exp_dest) & dest_mask) == '0 && ((old_tag ^ exp_old) & tag_mask) == '0)
        else begin
            dest_err = dest_err + 1;
            $display("Mismatch at %0t: dest_tag or old_tag on a fired lane", $time);
        end

    assert property (@(posedge clock) disable iff (!rst_n || !exp_valid)
        ((lane_bank ^ exp_bank) & bank_mask) == '0)
        else begin
            bank_err = bank_err + 1;
            $display("Mismatch at %0t: lane_bank on a fired lane", $time);
        end

    // One clock edge with the model following the accepted lanes
    task automatic step();
        phys_tag_t t;
        @(posedge clock);
        if (exp_valid) begin
            if (wb_valid) begin
                ref_ready[wb_tag] = 1'b1;
            end
            // Allocation clears after writeback sets
            for (int i = 0; i < W; i++) begin
                if (dest_mask[i] != '0) begin
                    t = ref_free.pop_front();
                    ref_map[rd_idx[i]] = t;
                    ref_ready[t] = 1'b0;
                    retirable.push_back(exp_old[i]);
                end
            end
            if (retire_valid) begin
                ref_free.push_back(retire_tag);
            end
        end
    endtask

    // Random bundle over a small register range so lanes collide often
    task automatic drive_bundle(input bit drain);
        valid_count <= drain ? CW'(W) : CW'($unsigned($random(seed)) % (W + 1));
        for (int i = 0; i < W; i++) begin
            rs1_idx[i]  <= arch_idx_t'($unsigned($random(seed)) % 8);
            rs2_idx[i]  <= arch_idx_t'($unsigned($random(seed)) % 8);
            rd_idx[i]   <= arch_idx_t'($unsigned($random(seed)) % 8);
            uses_rd[i]  <= drain || (2'($random(seed)) != 2'd0);
            uses_rs2[i] <= 1'($random(seed));
            bank[i]     <= fu_bank_t'(2'($random(seed)));
        end
        // Zero counts show up often outside the drain
        rob_free       <= drain ? 7'd64 : slot_count_t'($unsigned($random(seed)) % 6);
        rs_alu_free    <= drain ? 7'd64 : slot_count_t'($unsigned($random(seed)) % 4);
        rs_mult_free   <= drain ? 7'd64 : slot_count_t'($unsigned($random(seed)) % 4);
        rs_branch_free <= drain ? 7'd64 : slot_count_t'($unsigned($random(seed)) % 4);
        rs_mem_free    <= drain ? 7'd64 : slot_count_t'($unsigned($random(seed)) % 4);
        wb_valid       <= 1'($random(seed));
        wb_tag         <= phys_tag_t'($random(seed));
    endtask

    initial begin
        int n;
        seed = 32'hd446_2a25;
        count_err = 0;
        src_err   = 0;
        dest_err  = 0;
        bank_err  = 0;
        wait_err  = 0;
        exp_valid = 1'b0;
        dest_mask = '0;
        // Model after reset holds the identity map and free tags 32 to 63
        for (int r = 0; r < ARCH_REG_COUNT; r++) begin
            ref_map[r] = phys_tag_t'(r);
        end
        for (int t = ARCH_REG_COUNT; t < PHYS_REG_COUNT; t++) begin
            ref_free.push_back(phys_tag_t'(t));
        end
        ref_ready = '1;
        rst_n = 1'b0;
        valid_count = '0;
        rs1_idx = '0;
        rs2_idx = '0;
        rd_idx = '0;
        uses_rd = '0;
        uses_rs2 = '0;
        bank = '{default: BANK_ALU};
        rob_free = '0;
        rs_alu_free = '0;
        rs_mult_free = '0;
        rs_branch_free = '0;
        rs_mem_free = '0;
        wb_valid = 1'b0;
        wb_tag = '0;
        retire_valid = 1'b0;
        retire_tag = '0;
        repeat (4) step();
        rst_n <= 1'b1;

        // Use up all free tags with no retire
        drive_bundle(1'b1);
        n = 0;
        @(negedge clock);
        while (dispatch_count != 0 && n < 40) begin
            step();
            drive_bundle(1'b1);
            @(negedge clock);
            n++;
        end
        if (dispatch_count != 0) begin
            wait_err++;
            $display("Timeout: lanes still dispatching after %0d bundles with no retire", n);
        end
        // Lanes writing rd must stall now
        repeat (2) begin
            step();
            drive_bundle(1'b1);
        end

        // One retired tag lets a single lane through
        if (retirable.size() > 0) begin
            retire_valid <= 1'b1;
            retire_tag   <= retirable.pop_front();
        end
        step();
        retire_valid <= 1'b0;
        n = 0;
        @(negedge clock);
        while (dispatch_count == 0 && n < 10) begin
            step();
            @(negedge clock);
            n++;
        end
        if (dispatch_count == 0) begin
            wait_err++;
            $display("Timeout: no lane dispatched after a tag was retired");
        end
        step();

        // Random traffic with retires queued behind older free tags
        repeat (300) begin
            drive_bundle(1'b0);
            retire_valid <= 1'b0;
            if (retirable.size() > 0 && 2'($random(seed)) != 2'd0) begin
                retire_valid <= 1'b1;
                retire_tag   <= retirable.pop_front();
            end
            step();
        end
        step();

        $display("Errors: count %0d, source %0d, dest %0d, bank %0d, wait %0d",
                 count_err, src_err, dest_err, bank_err, wait_err);
        if (count_err + src_err + dest_err + bank_err + wait_err == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* rename_dispatch.f */
hw/dispatch_pkg.sv
hw/dispatch_limiter.sv
hw/rename_map.sv
hw/phys_free_list.sv
hw/ready_table.sv
hw/rename_bypass.sv
hw/rename_dispatch.sv
tests/tb_rename_dispatch.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the rename and dispatch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rename_dispatch \
    -f rename_dispatch.f -o sim_rename_dispatch

./obj_dir/sim_rename_dispatch | tee sim.log

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
